//--- hw/tag_pkg.sv
/*
 * Tag tracker shared types
 * Tag width, request opcodes and the request, outbound, response and completion words
 */
package tag_pkg;

    // Tag width allows up to 64 tags
    localparam int TAG_BITS = 6;

    typedef logic [TAG_BITS-1:0] tag_t;

    // Request kinds
    typedef enum logic [1:0]
    {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_FENCE = 2'd2
    } opcode_t;

    // Incoming request, also the heap data word (42 bits)
    typedef struct packed
    {
        opcode_t     opcode;
        logic [31:0] addr;
        logic [7:0]  user;
    } req_meta_t;

    // Outbound request carries the tag, not the user field (40 bits)
    typedef struct packed
    {
        tag_t        tag;
        opcode_t     opcode;
        logic [31:0] addr;
    } out_req_t;

    // Response from the target (38 bits)
    typedef struct packed
    {
        tag_t        tag;
        logic [31:0] data;
    } rsp_t;

    // Completion joins stored metadata and response data (74 bits)
    typedef struct packed
    {
        req_meta_t   meta;
        logic [31:0] data;
    } cpl_t;

endpackage

//--- hw/simple_ram.sv
/*
 * Simple dual-port RAM
 * One write port, one read port, read data registered one cycle after the address
 */
`timescale 1ns/1ps

module simple_ram
#(
    parameter int DEPTH = 16,
    parameter int WIDTH = 8
)
(
    input  logic                     clk,

    input  logic                     wen,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [WIDTH-1:0]         wdata,

    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [WIDTH-1:0]         rdata
);

    // Storage array, no reset
    logic [WIDTH-1:0] mem [0:DEPTH-1];

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end

        // Read during write returns the old word
        rdata <= mem[raddr];
    end

endmodule

//--- hw/tag_heap.sv
/*
 * Tag heap
 * Hands out free tags from twin round-robin free lists and stores request
 * metadata under each tag until the response frees it
 */
`timescale 1ns/1ps

module tag_heap
    import tag_pkg::*;
#(
    parameter int N_TAGS         = 16,
    parameter int MIN_FREE_SLOTS = 1
)
(
    input  logic      clk,
    input  logic      reset,

    input  logic      alloc_en,
    input  req_meta_t alloc_data,
    output logic      alloc_ok,
    output tag_t      alloc_tag,

    input  tag_t      read_tag,
    output req_meta_t read_meta,

    input  logic      free_en,
    input  tag_t      free_tag
);

    localparam int IDX_BITS = $clog2(N_TAGS);

    typedef logic [IDX_BITS-1:0] idx_t;
    typedef logic [IDX_BITS:0]   cnt_t;

    // ==================================================================
    // Metadata store
    // ==================================================================

    // Written at allocation, read by the match stage
    simple_ram #(.DEPTH(N_TAGS), .WIDTH($bits(req_meta_t))) meta_ram
    (
        .clk   (clk),
        .wen   (alloc_en),
        .waddr (alloc_tag[IDX_BITS-1:0]),
        .wdata (alloc_data),
        .raddr (read_tag[IDX_BITS-1:0]),
        .rdata (read_meta)
    );

    // ==================================================================
    // Prefetch queue of ready tags
    // ==================================================================

    logic       pop_free;
    logic       free_idx_avail;
    idx_t       next_free_idx;
    idx_t       pf_data [0:1];
    logic [1:0] pf_count;
    logic       pf_wr_slot;

    // Pull from the free list whenever a slot is open
    assign pop_free   = (pf_count != 2'd2) && free_idx_avail;
    assign alloc_ok   = (pf_count != 2'd0);
    assign alloc_tag  = tag_t'(pf_data[0]);
    // Slot 1 only when one entry stays put
    assign pf_wr_slot = (pf_count == 2'd1) && !alloc_en;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pf_count <= 2'd0;
        end
        else
        begin
            pf_count <= pf_count + 2'(pop_free) - 2'(alloc_en);
        end

        // Shift on allocate, a new tag then lands in the freed slot
        if (alloc_en)
        begin
            pf_data[0] <= pf_data[1];
        end
        if (pop_free)
        begin
            pf_data[pf_wr_slot] <= next_free_idx;
        end
    end

    // ==================================================================
    // Twin free lists
    // ==================================================================

    // Two heads cover the two-cycle link read, pops alternate between them
    idx_t free_head [0:1];
    idx_t free_head_reg [0:1];
    idx_t free_tail [0:1];
    logic head_rr;
    logic head_rr_q;
    logic head_rr_qq;
    logic tail_rr;
    logic pop_q;
    logic pop_qq;

    logic free_wen;
    idx_t free_wdata;
    idx_t link_rdata;
    idx_t link_next_q;

    logic initialized;
    idx_t init_idx;
    logic free_q;
    idx_t free_idx_q;
    cnt_t num_free;

    assign next_free_idx = free_head[head_rr];

    simple_ram #(.DEPTH(N_TAGS), .WIDTH(IDX_BITS)) link_ram
    (
        .clk   (clk),
        .wen   (free_wen),
        .waddr (free_tail[tail_rr]),
        .wdata (free_wdata),
        .raddr (next_free_idx),
        .rdata (link_rdata)
    );

    // Head picks up the link word two cycles after its pop
    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            if (pop_qq && (head_rr_qq == 1'(i)))
                free_head[i] = link_next_q;
            else
                free_head[i] = free_head_reg[i];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pop_q            <= 1'b0;
            pop_qq           <= 1'b0;
            head_rr          <= 1'b0;
            // Tags 0 and 1 start as the list heads
            free_head_reg[0] <= idx_t'(0);
            free_head_reg[1] <= idx_t'(1);
        end
        else
        begin
            pop_q            <= pop_free;
            pop_qq           <= pop_q;
            free_head_reg[0] <= free_head[0];
            free_head_reg[1] <= free_head[1];
            if (pop_free)
                head_rr <= ~head_rr;
        end

        head_rr_q   <= head_rr;
        head_rr_qq  <= head_rr_q;
        // Extra stage on the link read for timing
        link_next_q <= link_rdata;
    end

    // Freed tags are pushed one cycle late
    always_ff @(posedge clk)
    begin
        if (reset)
            free_q <= 1'b0;
        else
            free_q <= free_en;

        free_idx_q <= free_tag[IDX_BITS-1:0];
    end

    // Init walk pushes every tag above the two heads
    assign free_wen   = !initialized || free_q;
    assign free_wdata = initialized ? free_idx_q : init_idx;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            free_tail[0] <= idx_t'(0);
            free_tail[1] <= idx_t'(1);
            tail_rr      <= 1'b0;
        end
        else if (free_wen)
        begin
            free_tail[tail_rr] <= free_wdata;
            tail_rr            <= ~tail_rr;
        end
    end

    // ==================================================================
    // Init walk and free count
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            init_idx       <= idx_t'(2);
            initialized    <= 1'b0;
            num_free       <= '0;
            free_idx_avail <= 1'b0;
        end
        else if (!initialized)
        begin
            init_idx <= init_idx + idx_t'(1);
            if (init_idx == idx_t'(N_TAGS - 1))
            begin
                initialized    <= 1'b1;
                // Two tags stay on the lists so neither head runs dry
                num_free       <= cnt_t'(N_TAGS - 2);
                free_idx_avail <= 1'b1;
            end
        end
        else if (free_q && !pop_free)
        begin
            num_free       <= num_free + cnt_t'(1);
            free_idx_avail <= (num_free + cnt_t'(1)) > cnt_t'(MIN_FREE_SLOTS);
        end
        else if (!free_q && pop_free)
        begin
            num_free       <= num_free - cnt_t'(1);
            free_idx_avail <= (num_free - cnt_t'(1)) > cnt_t'(MIN_FREE_SLOTS);
        end
    end

endmodule

//--- hw/req_issue.sv
/*
 * Request issue stage
 * Allocates a tag per request strobe, stores the metadata, registers the outbound request
 */
`timescale 1ns/1ps

module req_issue
    import tag_pkg::*;
#(
    parameter int N_TAGS = 16
)
(
    input  logic      clk,
    input  logic      reset,

    input  logic      req_valid,
    input  req_meta_t req,

    input  logic      alloc_ok,
    input  tag_t      alloc_tag,
    output logic      alloc_en,
    output req_meta_t alloc_data,

    output logic      req_ready,
    output logic      out_valid,
    output out_req_t  out_req
);

    localparam int IDX_BITS = $clog2(N_TAGS);

    // Ready follows the heap directly
    assign req_ready = alloc_ok;

    // Never pop an empty prefetch
    assign alloc_en   = req_valid && alloc_ok;
    assign alloc_data = req;

    always_ff @(posedge clk)
    begin
        if (reset)
            out_valid <= 1'b0;
        else
            out_valid <= alloc_en;

        // Payload, only the index bits of the tag are live
        out_req.tag    <= tag_t'(alloc_tag[IDX_BITS-1:0]);
        out_req.opcode <= req.opcode;
        out_req.addr   <= req.addr;
    end

endmodule

//--- hw/rsp_match.sv
/*
 * Response match stage
 * Looks up the metadata for a response tag, emits the completion and frees the tag
 */
`timescale 1ns/1ps

module rsp_match
    import tag_pkg::*;
#(
    parameter int N_TAGS = 16
)
(
    input  logic      clk,
    input  logic      reset,

    input  logic      rsp_valid,
    input  rsp_t      rsp,

    output tag_t      read_tag,
    input  req_meta_t read_meta,

    output logic      free_en,
    output tag_t      free_tag,

    output logic      cpl_valid,
    output cpl_t      cpl
);

    localparam int IDX_BITS = $clog2(N_TAGS);

    logic        rsp_valid_q;
    tag_t        rsp_tag_q;
    logic [31:0] rsp_data_q;

    // Heap read issued straight from the response
    assign read_tag = tag_t'(rsp.tag[IDX_BITS-1:0]);

    // Data and valid ride alongside the RAM read, one response per cycle
    always_ff @(posedge clk)
    begin
        if (reset)
            rsp_valid_q <= 1'b0;
        else
            rsp_valid_q <= rsp_valid;

        rsp_tag_q  <= read_tag;
        rsp_data_q <= rsp.data;
    end

    // Metadata arrives now, join it to the data
    assign cpl_valid = rsp_valid_q;
    assign cpl.meta  = read_meta;
    assign cpl.data  = rsp_data_q;

    // Tag goes back to the heap in the completion cycle
    assign free_en  = rsp_valid_q;
    assign free_tag = rsp_tag_q;

endmodule

//--- hw/tag_track_top.sv
/*
 * Request tag tracker top level
 * Issue stage, tag heap and response match stage
 */
`timescale 1ns/1ps

module tag_track_top
    import tag_pkg::*;
#(
    parameter int N_TAGS         = 16,
    parameter int MIN_FREE_SLOTS = 1
)
(
    input  logic      clk,
    input  logic      reset,

    input  logic      req_valid,
    input  req_meta_t req,
    output logic      req_ready,

    output logic      out_valid,
    output out_req_t  out_req,

    input  logic      rsp_valid,
    input  rsp_t      rsp,

    output logic      cpl_valid,
    output cpl_t      cpl
);

    // Issue side of the heap
    logic      alloc_ok;
    tag_t      alloc_tag;
    logic      alloc_en;
    req_meta_t alloc_data;

    // Match side of the heap
    tag_t      read_tag;
    req_meta_t read_meta;
    logic      free_en;
    tag_t      free_tag;

    req_issue #(.N_TAGS(N_TAGS)) u_issue
    (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .alloc_ok   (alloc_ok),
        .alloc_tag  (alloc_tag),
        .alloc_en   (alloc_en),
        .alloc_data (alloc_data),
        .req_ready  (req_ready),
        .out_valid  (out_valid),
        .out_req    (out_req)
    );

    tag_heap #(.N_TAGS(N_TAGS), .MIN_FREE_SLOTS(MIN_FREE_SLOTS)) u_heap
    (
        .clk        (clk),
        .reset      (reset),
        .alloc_en   (alloc_en),
        .alloc_data (alloc_data),
        .alloc_ok   (alloc_ok),
        .alloc_tag  (alloc_tag),
        .read_tag   (read_tag),
        .read_meta  (read_meta),
        .free_en    (free_en),
        .free_tag   (free_tag)
    );

    rsp_match #(.N_TAGS(N_TAGS)) u_match
    (
        .clk        (clk),
        .reset      (reset),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .read_tag   (read_tag),
        .read_meta  (read_meta),
        .free_en    (free_en),
        .free_tag   (free_tag),
        .cpl_valid  (cpl_valid),
        .cpl        (cpl)
    );

endmodule

//--- dv/tag_track_assert.sv
/*
 * Tag tracker protocol checks
 * Concurrent assertions on the handshakes, tag uniqueness and completion data
 */
`timescale 1ns/1ps

module tag_track_assert
    import tag_pkg::*;
#(
    parameter int N_TAGS = 16
)
(
    input logic      clk,
    input logic      reset,
    input logic      req_valid,
    input req_meta_t req,
    input logic      req_ready,
    input logic      out_valid,
    input out_req_t  out_req,
    input logic      rsp_valid,
    input rsp_t      rsp,
    input logic      cpl_valid,
    input cpl_t      cpl,
    input logic      alloc_en,
    input tag_t      alloc_tag,
    input logic      free_en,
    input tag_t      free_tag
);

    // Number of failed assertions
    int fail_count = 0;

    // Tags between allocation and free
    logic [63:0] busy;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy <= '0;
        end
        else
        begin
            if (free_en)
                busy[free_tag] <= 1'b0;
            if (alloc_en)
                busy[alloc_tag] <= 1'b1;
        end
    end

    // ====================================================================
    // Handshakes
    // ====================================================================

    // Outputs quiet right after reset
    a_reset_quiet: assert property (@(posedge clk)
        $past(reset) |-> !req_ready && !out_valid && !cpl_valid)
    else
    begin
        $error("outputs not low after reset");
        fail_count++;
    end

    // No request strobe while the heap is full
    a_req_ready: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> req_ready)
    else
    begin
        $error("request strobe while req_ready low");
        fail_count++;
    end

    a_out_after_req: assert property (@(posedge clk) disable iff (reset)
        req_valid |=> out_valid && out_req.opcode == $past(req.opcode)
                      && out_req.addr == $past(req.addr))
    else
    begin
        $error("outbound request missing or wrong one cycle after a request");
        fail_count++;
    end

    a_out_only_after_req: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> $past(req_valid))
    else
    begin
        $error("outbound request without a request the cycle before");
        fail_count++;
    end

    a_cpl_after_rsp: assert property (@(posedge clk) disable iff (reset)
        rsp_valid |=> cpl_valid && cpl.data == $past(rsp.data))
    else
    begin
        $error("completion missing or wrong data one cycle after a response");
        fail_count++;
    end

    a_cpl_only_after_rsp: assert property (@(posedge clk) disable iff (reset)
        cpl_valid |-> $past(rsp_valid))
    else
    begin
        $error("completion without a response the cycle before");
        fail_count++;
    end

    // ====================================================================
    // Tag life cycle
    // ====================================================================

    a_alloc_unique: assert property (@(posedge clk) disable iff (reset)
        alloc_en |-> !busy[alloc_tag])
    else
    begin
        $error("tag allocated while still in use");
        fail_count++;
    end

    // One free per allocation
    a_free_once: assert property (@(posedge clk) disable iff (reset)
        free_en |-> busy[free_tag])
    else
    begin
        $error("tag freed without a matching allocation");
        fail_count++;
    end

endmodule

bind tag_track_top tag_track_assert #(.N_TAGS(N_TAGS)) u_assert
(
    .clk       (clk),
    .reset     (reset),
    .req_valid (req_valid),
    .req       (req),
    .req_ready (req_ready),
    .out_valid (out_valid),
    .out_req   (out_req),
    .rsp_valid (rsp_valid),
    .rsp       (rsp),
    .cpl_valid (cpl_valid),
    .cpl       (cpl),
    .alloc_en  (alloc_en),
    .alloc_tag (alloc_tag),
    .free_en   (free_en),
    .free_tag  (free_tag)
);

//--- dv/tag_track_tb.sv
/*
 * Tag tracker testbench
 * LFSR-driven requests, an out-of-order responder and per-cycle checks
 */
`timescale 1ns/1ps

module tag_track_tb
    import tag_pkg::*;
();

    localparam int N_TAGS          = 16;
    localparam int MIN_FREE_SLOTS  = 1;
    localparam int CLK_PERIOD      = 8;
    localparam int N_REQS          = 200;
    localparam int WATCHDOG_CYCLES = N_REQS * 20;
    // Outstanding count at which no tag is left to hand out
    localparam int FULL_LEVEL      = N_TAGS - 2 - MIN_FREE_SLOTS;

    logic      clk;
    logic      reset;
    logic      req_valid;
    req_meta_t req;
    logic      req_ready;
    logic      out_valid;
    out_req_t  out_req;
    logic      rsp_valid;
    rsp_t      rsp;
    logic      cpl_valid;
    cpl_t      cpl;

    // Responder model, outstanding tags and their metadata
    tag_t        pending [$];
    req_meta_t   meta_of [0:63];
    logic [63:0] tag_busy;
    logic        last_req_valid;
    req_meta_t   last_req;
    logic        last_rsp_valid;
    req_meta_t   last_rsp_meta;

    logic [31:0] lfsr_state;
    int          issued;
    int          completions;
    int          value_errors;
    int          assert_errors;

    tag_track_top #(.N_TAGS(N_TAGS), .MIN_FREE_SLOTS(MIN_FREE_SLOTS)) DUT
    (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .out_valid (out_valid),
        .out_req   (out_req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .cpl_valid (cpl_valid),
        .cpl       (cpl)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ====================================================================
    // Random source and checks
    // ====================================================================

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [73:0] got,
                               input logic [73:0] exp);
        assert (got === exp)
        else
        begin
            $display("error %s got %h expected %h", name, got, exp);
            value_errors++;
        end
    endtask

    // Outputs at the falling edge reflect the inputs of the cycle before
    task automatic check_outputs();
        tag_t tag;
        cpl_t exp_cpl;
        check_value("out_valid", 74'(out_valid), 74'(last_req_valid));
        if (last_req_valid && out_valid)
        begin
            check_value("out_req.opcode", 74'(out_req.opcode), 74'(last_req.opcode));
            check_value("out_req.addr", 74'(out_req.addr), 74'(last_req.addr));
            tag = out_req.tag;
            assert (!tag_busy[tag] && int'(tag) < N_TAGS)
            else
            begin
                $display("Tag %0d handed out while outstanding or out of range", tag);
                value_errors++;
            end
            tag_busy[tag] = 1'b1;
            meta_of[tag]  = last_req;
            pending.push_back(tag);
        end
        check_value("cpl_valid", 74'(cpl_valid), 74'(last_rsp_valid));
        if (last_rsp_valid && cpl_valid)
        begin
            exp_cpl.meta = last_rsp_meta;
            exp_cpl.data = ~last_rsp_meta.addr;
            check_value("cpl", cpl, exp_cpl);
            completions++;
        end
        // Saturated heap refuses further requests
        if (pending.size() >= FULL_LEVEL)
        begin
            assert (!req_ready)
            else
            begin
                $display("req_ready high with %0d tags outstanding", pending.size());
                value_errors++;
            end
        end
    endtask

    // ====================================================================
    // Stimulus
    // ====================================================================

    task automatic drive_inputs(input logic want_send, input logic want_answer);
        int   idx;
        tag_t tag;
        req_valid      = 1'b0;
        rsp_valid      = 1'b0;
        last_req_valid = 1'b0;
        last_rsp_valid = 1'b0;
        if (want_send && req_ready && issued < N_REQS)
        begin
            req.opcode     = opcode_t'(2'(random_bits(2) % 3));
            req.addr       = random_bits(32);
            req.user       = 8'(random_bits(8));
            req_valid      = 1'b1;
            last_req_valid = 1'b1;
            last_req       = req;
            issued++;
        end
        // Answer a random outstanding tag with the inverted address
        if (want_answer && pending.size() > 0)
        begin
            idx = int'(random_bits(6)) % pending.size();
            tag = pending[idx];
            pending.delete(idx);
            tag_busy[tag]  = 1'b0;
            rsp.tag        = tag;
            rsp.data       = ~meta_of[tag].addr;
            rsp_valid      = 1'b1;
            last_rsp_valid = 1'b1;
            last_rsp_meta  = meta_of[tag];
        end
    endtask

    task automatic tick(input logic want_send, input logic want_answer);
        @(negedge clk);
        check_outputs();
        drive_inputs(want_send, want_answer);
    endtask

    task automatic wait_ready(input string when_text);
        int cycles;
        cycles = 0;
        while (!req_ready && cycles < N_TAGS + 4)
        begin
            tick(1'b0, 1'b0);
            cycles++;
        end
        assert (req_ready)
        else
        begin
            $display("req_ready did not rise within %0d cycles %s", N_TAGS + 4, when_text);
            value_errors++;
        end
    endtask

    // Send about half the cycles, answer about three in four
    task automatic run_random(input int until_count);
        logic send_bit;
        logic answer_bit;
        while (issued < until_count)
        begin
            send_bit   = 1'(random_bits(1));
            answer_bit = (2'(random_bits(2)) != 2'd0);
            tick(send_bit, answer_bit);
        end
    endtask

    task automatic drain();
        while (pending.size() > 0 || last_req_valid || last_rsp_valid)
        begin
            tick(1'b0, 1'b1);
        end
    endtask

    initial
    begin
        reset          = 1'b1;
        req_valid      = 1'b0;
        req            = '0;
        rsp_valid      = 1'b0;
        rsp            = '0;
        lfsr_state     = 32'd67960;
        issued         = 0;
        completions    = 0;
        value_errors   = 0;
        tag_busy       = '0;
        last_req_valid = 1'b0;
        last_req       = '0;
        last_rsp_valid = 1'b0;
        last_rsp_meta  = '0;

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("req_ready", 74'(req_ready), 74'(1'b0));
        check_value("out_valid", 74'(out_valid), 74'(1'b0));
        check_value("cpl_valid", 74'(cpl_valid), 74'(1'b0));
        // Heap init walk and prefetch fill
        wait_ready("after reset");

        run_random(120);
        drain();

        // Flood until no tag is left, then answer all in random order
        while (pending.size() < FULL_LEVEL)
        begin
            tick(1'b1, 1'b0);
        end
        repeat (4) tick(1'b0, 1'b0);
        drain();
        wait_ready("after the flood drained");

        run_random(N_REQS);
        drain();

        check_value("completions", 74'(completions), 74'(issued));
        assert_errors = DUT.u_assert.fail_count;
        $display("Check summary: value errors %0d, assertion failures %0d, %0d requests",
                 value_errors, assert_errors, issued);
        if (value_errors == 0 && assert_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- list.f
hw/tag_pkg.sv
hw/simple_ram.sv
hw/tag_heap.sv
hw/req_issue.sv
hw/rsp_match.sv
hw/tag_track_top.sv
dv/tag_track_assert.sv
dv/tag_track_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the tag tracker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tag_track_tb -o sim
out=$(./obj_dir/sim +verilator+error+limit+1000 || true)
echo "$out"

if echo "$out" | grep -q "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi
